/* logic/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and address width
`define RV_XLEN 32

// architectural registers, indexed by 5 bits
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// major opcodes of the kept instruction groups
`define RV_OP_LUI 7'b0110111
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_IMM 7'b0010011
`define RV_OP_REG 7'b0110011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_SYSTEM 7'b1110011

// funct7 for sub, sra and srai
`define RV_F7_ALT 7'b0100000

`endif

/* logic/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

  // one instruction word seen through each encoding layout
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } insn_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  typedef struct packed {
    alu_op_e    alu_op;
    br_cond_e   br_cond;
    logic       use_imm;
    logic       use_pc;
    logic       we;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       is_ecall;
  } ctrl_t;

  // decode to execute
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
  } ex_stage_t;

  // execute to memory, memory to writeback
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    logic                we;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] result;
    logic                is_ecall;
  } wb_stage_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    logic                we;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] result;
  } retire_t;

endpackage

/* logic/rv_decoder.sv */
`include "rv_defines.svh"

module rv_decoder (
  input  rv_pkg::insn_u        insn_i,
  output rv_pkg::ctrl_t        ctrl_o,
  output logic [`RV_XLEN-1:0]  imm_o
);

  logic [`RV_XLEN-1:0] imm_i_type;
  logic [`RV_XLEN-1:0] imm_b_type;
  logic [`RV_XLEN-1:0] imm_u_type;

  assign imm_i_type = {{(`RV_XLEN-12){insn_i.i_fmt.imm12[11]}}, insn_i.i_fmt.imm12};
  assign imm_b_type = {{(`RV_XLEN-13){insn_i.b_fmt.imm_12}}, insn_i.b_fmt.imm_12,
                       insn_i.b_fmt.imm_11, insn_i.b_fmt.imm_10_5, insn_i.b_fmt.imm_4_1, 1'b0};
  assign imm_u_type = {insn_i.u_fmt.imm20, 12'd0};

  always_comb begin
    ctrl_o = '0;
    ctrl_o.alu_op = rv_pkg::ALU_ADD;
    ctrl_o.br_cond = rv_pkg::BR_NONE;
    ctrl_o.rd = insn_i.r_fmt.rd;
    ctrl_o.rs1 = insn_i.r_fmt.rs1;
    ctrl_o.rs2 = insn_i.r_fmt.rs2;
    imm_o = imm_i_type;

    case (insn_i.r_fmt.opcode)
      `RV_OP_LUI: begin
        ctrl_o.alu_op = rv_pkg::ALU_PASS_B;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.we = 1'b1;
        imm_o = imm_u_type;
      end
      `RV_OP_AUIPC: begin
        ctrl_o.use_pc = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.we = 1'b1;
        imm_o = imm_u_type;
      end
      `RV_OP_IMM: begin
        ctrl_o.use_imm = 1'b1;
        ctrl_o.we = 1'b1;
        case (insn_i.i_fmt.funct3)
          3'b000: ctrl_o.alu_op = rv_pkg::ALU_ADD;
          3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = rv_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = rv_pkg::ALU_SLL;
            ctrl_o.we = (insn_i.r_fmt.funct7 == 7'd0);
          end
          default: begin
            // shift right, upper imm bits pick arithmetic or logical
            ctrl_o.alu_op = (insn_i.r_fmt.funct7 == `RV_F7_ALT) ? rv_pkg::ALU_SRA
                                                                : rv_pkg::ALU_SRL;
            ctrl_o.we = (insn_i.r_fmt.funct7 == 7'd0) || (insn_i.r_fmt.funct7 == `RV_F7_ALT);
          end
        endcase
      end
      `RV_OP_REG: begin
        ctrl_o.we = (insn_i.r_fmt.funct7 == 7'd0);
        case (insn_i.r_fmt.funct3)
          3'b000: ctrl_o.alu_op = rv_pkg::ALU_ADD;
          3'b001: ctrl_o.alu_op = rv_pkg::ALU_SLL;
          3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
          3'b101: ctrl_o.alu_op = rv_pkg::ALU_SRL;
          3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
          default: ctrl_o.alu_op = rv_pkg::ALU_AND;
        endcase
        // alternate funct7 only exists for sub and sra
        if (insn_i.r_fmt.funct7 == `RV_F7_ALT) begin
          if (insn_i.r_fmt.funct3 == 3'b000) begin
            ctrl_o.alu_op = rv_pkg::ALU_SUB;
            ctrl_o.we = 1'b1;
          end else if (insn_i.r_fmt.funct3 == 3'b101) begin
            ctrl_o.alu_op = rv_pkg::ALU_SRA;
            ctrl_o.we = 1'b1;
          end
        end
      end
      `RV_OP_BRANCH: begin
        imm_o = imm_b_type;
        case (insn_i.b_fmt.funct3)
          3'b000: ctrl_o.br_cond = rv_pkg::BR_EQ;
          3'b001: ctrl_o.br_cond = rv_pkg::BR_NE;
          3'b100: ctrl_o.br_cond = rv_pkg::BR_LT;
          3'b101: ctrl_o.br_cond = rv_pkg::BR_GE;
          3'b110: ctrl_o.br_cond = rv_pkg::BR_LTU;
          3'b111: ctrl_o.br_cond = rv_pkg::BR_GEU;
          default: ctrl_o.br_cond = rv_pkg::BR_NONE;
        endcase
      end
      `RV_OP_SYSTEM: begin
        ctrl_o.is_ecall = (insn_i.i_fmt.imm12 == 12'd0) && (insn_i.i_fmt.rs1 == 5'd0) &&
                          (insn_i.i_fmt.funct3 == 3'd0) && (insn_i.i_fmt.rd == 5'd0);
      end
      default: begin
        // unknown encoding, left as a no-op
        ctrl_o.we = 1'b0;
      end
    endcase

    // writes to x0 are dropped here so nothing downstream forwards them
    if (ctrl_o.rd == 5'd0) begin
      ctrl_o.we = 1'b0;
    end
  end

endmodule

/* logic/rv_regfile.sv */
`include "rv_defines.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic                we_i,
  input  logic [4:0]          rd_i,
  input  logic [`RV_XLEN-1:0] rd_data_i,
  input  logic [4:0]          rs1_i,
  input  logic [4:0]          rs2_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 reads zero, same-cycle write passes straight through
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] idx);
    logic [`RV_XLEN-1:0] val;
    val = regs[idx];
    if (idx == 5'd0) begin
      val = '0;
    end else if (we_i && (rd_i == idx)) begin
      val = rd_data_i;
    end
    return val;
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

/* logic/rv_execute.sv */
`include "rv_defines.svh"

module rv_execute (
  input  rv_pkg::ex_stage_t   ex_i,
  input  rv_pkg::wb_stage_t   mem_fwd_i,
  input  rv_pkg::wb_stage_t   wb_fwd_i,
  output rv_pkg::wb_stage_t   result_o,
  output logic                branch_taken_o,
  output logic [`RV_XLEN-1:0] branch_target_o
);

  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond_true;
  logic [`RV_XLEN-1:0] alu_out;

  // memory record wins over writeback, x0 never forwards
  function automatic logic [`RV_XLEN-1:0] pick_src(
      input logic [4:0]          idx,
      input logic [`RV_XLEN-1:0] reg_val,
      input rv_pkg::wb_stage_t   mem_rec,
      input rv_pkg::wb_stage_t   wb_rec);
    logic [`RV_XLEN-1:0] val;
    val = reg_val;
    if (idx != 5'd0) begin
      if (mem_rec.valid && mem_rec.we && (mem_rec.rd == idx)) begin
        val = mem_rec.result;
      end else if (wb_rec.valid && wb_rec.we && (wb_rec.rd == idx)) begin
        val = wb_rec.result;
      end
    end
    return val;
  endfunction

  assign rs1_fwd = pick_src(ex_i.ctrl.rs1, ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
  assign rs2_fwd = pick_src(ex_i.ctrl.rs2, ex_i.rs2_val, mem_fwd_i, wb_fwd_i);

  // auipc takes the pc, immediates replace rs2
  assign op_a  = ex_i.ctrl.use_pc ? ex_i.pc : rs1_fwd;
  assign op_b  = ex_i.ctrl.use_imm ? ex_i.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  // shared by slt/sltu and the branch compare
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  always_comb begin
    case (ex_i.ctrl.alu_op)
      rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_out = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_out = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_out = op_a | op_b;
      rv_pkg::ALU_AND:    alu_out = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_out = op_b;
      default:            alu_out = '0;
    endcase
  end

  always_comb begin
    case (ex_i.ctrl.br_cond)
      rv_pkg::BR_EQ:  cond_true = eq;
      rv_pkg::BR_NE:  cond_true = !eq;
      rv_pkg::BR_LT:  cond_true = lt_s;
      rv_pkg::BR_GE:  cond_true = !lt_s;
      rv_pkg::BR_LTU: cond_true = lt_u;
      rv_pkg::BR_GEU: cond_true = !lt_u;
      default:        cond_true = 1'b0;
    endcase
  end

  assign branch_taken_o  = ex_i.valid && cond_true;
  assign branch_target_o = ex_i.pc + ex_i.imm;

  assign result_o = '{
    valid:    ex_i.valid,
    pc:       ex_i.pc,
    insn:     ex_i.insn,
    we:       ex_i.valid && ex_i.ctrl.we,
    rd:       ex_i.ctrl.rd,
    result:   alu_out,
    is_ecall: ex_i.valid && ex_i.ctrl.is_ecall
  };

endmodule

/* logic/rv_core.sv */
`include "rv_defines.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [`RV_XLEN-1:0] imem_data_i,
  output rv_pkg::retire_t     retire_o,
  output logic                halt_o
);

  logic [`RV_XLEN-1:0] pc_q;

  // decode register
  logic                dec_valid_q;
  logic [`RV_XLEN-1:0] dec_pc_q;
  rv_pkg::insn_u       dec_insn_q;

  rv_pkg::ctrl_t       dec_ctrl;
  logic [`RV_XLEN-1:0] dec_imm;
  logic [`RV_XLEN-1:0] dec_rs1_val;
  logic [`RV_XLEN-1:0] dec_rs2_val;

  rv_pkg::ex_stage_t   ex_d;
  rv_pkg::ex_stage_t   ex_q;
  rv_pkg::wb_stage_t   ex_result;
  rv_pkg::wb_stage_t   mem_q;
  rv_pkg::wb_stage_t   wb_q;

  logic                branch_taken;
  logic [`RV_XLEN-1:0] branch_target;
  logic                halted_q;

  // high from the cycle ecall sits in writeback
  assign halt_o = halted_q || (wb_q.valid && wb_q.is_ecall);

  assign imem_addr_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else if (!halt_o) begin
      if (branch_taken) begin
        pc_q <= branch_target;
      end else begin
        pc_q <= pc_q + `RV_XLEN'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    dec_pc_q   <= pc_q;
    dec_insn_q <= imem_data_i;
    if (rst) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= !(branch_taken || halt_o);
    end
  end

  rv_decoder u_decoder (
    .insn_i (dec_insn_q),
    .ctrl_o (dec_ctrl),
    .imm_o  (dec_imm)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_q.valid && wb_q.we),
    .rd_i       (wb_q.rd),
    .rd_data_i  (wb_q.result),
    .rs1_i      (dec_ctrl.rs1),
    .rs2_i      (dec_ctrl.rs2),
    .rs1_data_o (dec_rs1_val),
    .rs2_data_o (dec_rs2_val)
  );

  assign ex_d = '{
    valid:   dec_valid_q,
    pc:      dec_pc_q,
    insn:    dec_insn_q,
    ctrl:    dec_ctrl,
    imm:     dec_imm,
    rs1_val: dec_rs1_val,
    rs2_val: dec_rs2_val
  };

  // a taken branch kills the two younger slots
  always_ff @(posedge clk) begin
    ex_q <= ex_d;
    if (rst || branch_taken || halt_o) begin
      ex_q.valid <= 1'b0;
    end
  end

  rv_execute u_execute (
    .ex_i            (ex_q),
    .mem_fwd_i       (mem_q),
    .wb_fwd_i        (wb_q),
    .result_o        (ex_result),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

  // memory stage only carries the record
  always_ff @(posedge clk) begin
    mem_q <= ex_result;
    if (rst || halt_o) begin
      mem_q.valid    <= 1'b0;
      mem_q.we       <= 1'b0;
      mem_q.is_ecall <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    wb_q <= mem_q;
    if (rst || halt_o) begin
      wb_q.valid    <= 1'b0;
      wb_q.we       <= 1'b0;
      wb_q.is_ecall <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (wb_q.valid && wb_q.is_ecall) begin
      halted_q <= 1'b1;
    end
  end

  assign retire_o = '{
    valid:  wb_q.valid,
    pc:     wb_q.pc,
    insn:   wb_q.insn,
    we:     wb_q.we,
    rd:     wb_q.rd,
    result: wb_q.result
  };

endmodule

/* verification/tb_clock.sv */
module tb_clock (
  output logic clk_o
);

  // period of 100 time units
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

endmodule

/* verification/rv_core_asserts.sv */
`include "rv_defines.svh"

module rv_core_asserts (
  input logic                clk,
  input logic                rst,
  input rv_pkg::retire_t     retire_i,
  input logic                halt_i,
  input logic [`RV_XLEN-1:0] imem_addr_i
);

  // a retired register write never names x0
  a_retire_rd: assert property (@(posedge clk) disable iff (rst)
    (retire_i.valid && retire_i.we) |-> (retire_i.rd != 5'd0))
    else $error("retire record writes x0");

  // halt is sticky until the next reset
  a_halt_sticky: assert property (@(posedge clk)
    $fell(halt_i) |-> $past(rst))
    else $error("halt_o dropped without a reset");

  a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    imem_addr_i[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

endmodule

/* verification/rv_core_tb.sv */
`include "rv_defines.svh"

module rv_core_tb;

  localparam int PROG_LEN = 48;
  localparam int NUM_PROGS = 4;
  localparam int MEM_WORDS = 64;
  localparam int RESET_CYCLES = 5;
  localparam int DRAIN_CYCLES = 6;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 3 + 20);

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_data;
  rv_pkg::retire_t     retire;
  logic                halt;

  logic [`RV_XLEN-1:0] imem [MEM_WORDS];
  rv_pkg::retire_t     expected_q [$];
  logic [`RV_XLEN-1:0] ecall_pc;
  integer              seed;
  int                  cycle_count = 0;

  tb_clock u_clock (
    .clk_o (clk)
  );

  rv_core u_rv_core (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .retire_o    (retire),
    .halt_o      (halt)
  );

  bind rv_core rv_core_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .retire_i    (retire_o),
    .halt_i      (halt_o),
    .imem_addr_i (imem_addr_o)
  );

  // instruction memory answers combinationally
  assign imem_data = imem[imem_addr[7:2]];

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic string retire_text(input rv_pkg::retire_t r);
    return $sformatf("pc=%h insn=%h we=%b rd=%0d result=%h",
                     r.pc, r.insn, r.we, r.rd, r.result);
  endfunction

  task automatic check_retire(input string name, input rv_pkg::retire_t want,
                              input rv_pkg::retire_t got);
    logic bad;
    bad = (got.pc !== want.pc) || (got.insn !== want.insn) || (got.we !== want.we);
    // rd and result only mean something for a register write
    if (want.we && ((got.rd !== want.rd) || (got.result !== want.result))) begin
      bad = 1'b1;
    end
    if (bad) begin
      stop_run($sformatf("FAIL %s: expected %s, actual %s", name,
                         retire_text(want), retire_text(got)));
    end
  endtask

  task automatic check_halt_pc(input string name, input logic [`RV_XLEN-1:0] want,
                               input logic [`RV_XLEN-1:0] got);
    if (got !== want) begin
      stop_run($sformatf("FAIL %s: expected %h, actual %h", name, want, got));
    end
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'd0, $signed(a) < $signed(b)};
      3'b011: return {31'd0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // x0..x7 only, so dependencies at distance 1 to 3 come up often
  task automatic gen_program();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [6:0]  f7;
    int          skip;
    int          i;
    // opcode field stays zero past the program, which decodes as a no-op
    for (i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'b0000000};
    end
    for (i = 0; i < PROG_LEN - 1; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      kind = r1[15:12];
      rd = {2'b00, r1[2:0]};
      rs1 = {2'b00, r1[5:3]};
      rs2 = {2'b00, r1[8:6]};
      f3 = r1[11:9];
      imm12 = r1[27:16];
      f7 = (r2[24] && (f3 == 3'b000 || f3 == 3'b101)) ? `RV_F7_ALT : 7'd0;
      if (kind == 4'd0) begin
        imem[i] = u_type(r2[19:0], rd, `RV_OP_LUI);
      end else if (kind == 4'd1) begin
        imem[i] = u_type(r2[19:0], rd, `RV_OP_AUIPC);
      end else if (kind >= 4'd13 && i + 6 < PROG_LEN) begin
        // forward target 2 to 6 words ahead, never past the ecall
        skip = 2 + int'(r2[23:20]) % 5;
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        imem[i] = b_type(13'(skip * 4), rs2, rs1, f3);
      end else if (kind >= 4'd8) begin
        imem[i] = r_type(f7, rs2, rs1, f3, rd, `RV_OP_REG);
      end else begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm12 = {f7, imm12[4:0]};
        end
        imem[i] = i_type(imm12, rs1, f3, rd, `RV_OP_IMM);
      end
    end
    imem[PROG_LEN - 1] = {25'd0, `RV_OP_SYSTEM};
  endtask

  // in-order ISA model, one record per executed instruction
  task automatic run_model();
    logic [31:0]     xr [32];
    logic [31:0]     pc;
    logic [31:0]     next_pc;
    logic [31:0]     w;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [31:0]     imm_i;
    logic [31:0]     imm_b;
    logic [6:0]      op;
    logic [4:0]      rd;
    logic [2:0]      f3;
    logic            alt;
    logic            wr;
    logic            done;
    rv_pkg::retire_t rec;
    int              k;
    expected_q.delete();
    for (k = 0; k < 32; k++) begin
      xr[k] = '0;
    end
    pc = `RV_RESET_PC;
    done = 1'b0;
    while (!done && pc < 32'(MEM_WORDS * 4)) begin
      w = imem[pc[7:2]];
      op = w[6:0];
      rd = w[11:7];
      f3 = w[14:12];
      a = xr[w[19:15]];
      b = xr[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      alt = (w[31:25] == `RV_F7_ALT) && (op == `RV_OP_REG || f3 == 3'b101);
      res = '0;
      wr = 1'b0;
      next_pc = pc + 32'd4;
      case (op)
        `RV_OP_LUI: begin
          res = {w[31:12], 12'd0};
          wr = 1'b1;
        end
        `RV_OP_AUIPC: begin
          res = pc + {w[31:12], 12'd0};
          wr = 1'b1;
        end
        `RV_OP_IMM: begin
          res = alu_ref(f3, alt, a, imm_i);
          wr = 1'b1;
        end
        `RV_OP_REG: begin
          res = alu_ref(f3, alt, a, b);
          wr = 1'b1;
        end
        `RV_OP_BRANCH: begin
          if (branch_ref(f3, a, b)) begin
            next_pc = pc + imm_b;
          end
        end
        `RV_OP_SYSTEM: begin
          done = 1'b1;
          ecall_pc = pc;
        end
        default: begin
          wr = 1'b0;
        end
      endcase
      rec = '{valid: 1'b1, pc: pc, insn: w, we: wr && (rd != 5'd0), rd: rd, result: res};
      expected_q.push_back(rec);
      if (wr && rd != 5'd0) begin
        xr[rd] = res;
      end
      pc = next_pc;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_program(input int prog);
    rv_pkg::retire_t want;
    int              n;
    logic            halted;
    n = 0;
    halted = 1'b0;
    if (retire.valid !== 1'b0 || retire.we !== 1'b0 || halt !== 1'b0) begin
      stop_run("retire valid, retire we or halt is high right after reset");
    end
    while (!halted) begin
      @(negedge clk);
      if (retire.valid) begin
        if (expected_q.size() == 0) begin
          stop_run("core retired more instructions than the model");
        end
        want = expected_q.pop_front();
        check_retire($sformatf("prog%0d retire%0d", prog, n), want, retire);
        n++;
      end
      if (halt) begin
        if (expected_q.size() != 0 || !retire.valid) begin
          stop_run("halt_o rose before the ecall retired");
        end
        check_halt_pc($sformatf("prog%0d halt pc", prog), ecall_pc, retire.pc);
        halted = 1'b1;
      end else if (retire.valid && expected_q.size() == 0) begin
        stop_run("ecall retired without raising halt_o");
      end
    end
    // nothing younger than the ecall may retire
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (retire.valid) begin
        stop_run("an instruction retired after the halt");
      end
      if (!halt) begin
        stop_run("halt_o fell while the core was halted");
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_run($sformatf("timeout after %0d cycles without finishing", TIMEOUT_CYCLES));
    end
  end

  initial begin
    rst = 1'b1;
    seed = 80990;
    for (int p = 0; p < NUM_PROGS; p++) begin
      gen_program();
      run_model();
      apply_reset();
      run_program(p);
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
verification/tb_clock.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f

out=$(./obj_dir/Vrv_core_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'sim passed'; then
  exit 0
else
  exit 1
fi
